// ==== bfly_config.svh ====
`ifndef BFLY_CONFIG_SVH
`define BFLY_CONFIG_SVH

// Network size, initiators and targets are equal in number
`define BFLY_NUM_PORTS 8

// Port index width, also the number of radix-2 stages
`define BFLY_ADDR_W 3

// Payload widths
`define BFLY_REQ_DATA_W 32
`define BFLY_RESP_DATA_W 32

// Priority generator
`define BFLY_LFSR_W 16

// Galois taps for x^16 + x^14 + x^13 + x^11 + 1, right-shifting form
`define BFLY_LFSR_TAPS 16'hB400

// Reset states of the two generators, both must be nonzero
`define BFLY_REQ_SEED 16'hACE1
`define BFLY_RESP_SEED 16'h5A3C

`endif

// ==== bflyReqPkg.sv ====
`include "bfly_config.svh"

package bflyReqPkg;

  // Index of an initiator or a target port
  typedef logic [`BFLY_ADDR_W-1:0] portAddrT;

  // Request word as it travels through the stages
  //
  // tgtAddr is consumed MSB first, one bit per stage, and is shifted
  // left on every hop, so it reads zero at the target.
  // iniAddr is stamped with the sender index at the network edge and
  // passes through untouched.
  typedef struct packed {
    portAddrT                    tgtAddr;
    portAddrT                    iniAddr;
    logic [`BFLY_REQ_DATA_W-1:0] wdata;
  } bflyReqT;

endpackage

// ==== bflyRespPkg.sv ====
`include "bfly_config.svh"

package bflyRespPkg;

  // Response word as it travels back through the stages
  //
  // iniRoute holds one steering bit per stage, LSB first in the order the
  // stages are met on the way back, and is shifted right on every hop.
  typedef struct packed {
    logic [`BFLY_ADDR_W-1:0]      iniRoute;
    logic [`BFLY_RESP_DATA_W-1:0] rdata;
  } bflyRespT;

endpackage

// ==== bflyPrioLfsr.sv ====
`timescale 1ns/1ps
`include "bfly_config.svh"

module bflyPrioLfsr
  import bflyReqPkg::*;
#(
  parameter logic [`BFLY_LFSR_W-1:0] Seed = `BFLY_REQ_SEED
) (
  input  logic     clk_i,
  input  logic     rstN_i,
  input  logic     advance_i,
  output portAddrT prio_o
);

  logic [`BFLY_LFSR_W-1:0] lfsrQ;
  logic [`BFLY_LFSR_W-1:0] lfsrD;

  // The bit shifted out of a Galois step folds back into the tap positions
  assign lfsrD = (lfsrQ >> 1) ^ ({`BFLY_LFSR_W{lfsrQ[0]}} & `BFLY_LFSR_TAPS);

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      lfsrQ <= Seed;
    end else if (advance_i) begin
      lfsrQ <= lfsrD;
    end
  end

  // Bit l steers the arbiters of stage l
  assign prio_o = lfsrQ[`BFLY_ADDR_W-1:0];

  // An all-zero state would lock the priority pattern
  assert property (@(posedge clk_i) disable iff (!rstN_i) lfsrQ != '0)
    else $error("bflyPrioLfsr: LFSR state reached zero");

endmodule

// ==== bflySwitchbox.sv ====
`timescale 1ns/1ps
`include "bfly_config.svh"

module bflySwitchbox
  import bflyReqPkg::*;
  import bflyRespPkg::*;
(
  input  logic           clk_i,
  input  logic           rstN_i,
  // Requests from the initiator side
  input  logic     [1:0] reqValid_i,
  input  bflyReqT  [1:0] reqData_i,
  output logic     [1:0] reqReady_o,
  // Requests toward the target side
  output logic     [1:0] reqValid_o,
  output bflyReqT  [1:0] reqData_o,
  input  logic     [1:0] reqReady_i,
  // Responses from the target side
  input  logic     [1:0] respValid_i,
  input  bflyRespT [1:0] respData_i,
  output logic     [1:0] respReady_o,
  // Responses toward the initiator side
  output logic     [1:0] respValid_o,
  output bflyRespT [1:0] respData_o,
  input  logic     [1:0] respReady_i,
  // Stage priority bits, the input with this index wins a conflict
  input  logic           reqPrio_i,
  input  logic           respPrio_i
);

  // Output port asked for by each input
  logic [1:0] reqSel;
  logic [1:0] respSel;

  // Grants indexed as [output][input]
  logic [1:0][1:0] reqGrant;
  logic [1:0][1:0] respGrant;

  // Resolve one output, a lone request passes and a conflict goes to prio
  function automatic logic [1:0] arbitrate(input logic [1:0] want, input logic prio);
    logic [1:0] grant;
    grant = want;
    if (want == 2'b11) begin
      grant = prio ? 2'b10 : 2'b01;
    end
    return grant;
  endfunction

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      reqSel[k]  = reqData_i[k].tgtAddr[`BFLY_ADDR_W-1];
      respSel[k] = respData_i[k].iniRoute[0];
    end
  end

  for (genvar o = 0; o < 2; o++) begin : genOut
    logic [1:0] reqWant;
    logic [1:0] respWant;
    bflyReqT    reqWin;
    bflyRespT   respWin;

    for (genvar k = 0; k < 2; k++) begin : genWant
      assign reqWant[k]  = reqValid_i[k] && (reqSel[k] == 1'(o));
      assign respWant[k] = respValid_i[k] && (respSel[k] == 1'(o));
    end

    assign reqGrant[o]  = arbitrate(reqWant, reqPrio_i);
    assign respGrant[o] = arbitrate(respWant, respPrio_i);

    assign reqValid_o[o]  = |reqGrant[o];
    assign respValid_o[o] = |respGrant[o];

    assign reqWin  = reqGrant[o][1] ? reqData_i[1] : reqData_i[0];
    assign respWin = respGrant[o][1] ? respData_i[1] : respData_i[0];

    // Drop the steering bit used here so the next stage sees its own
    assign reqData_o[o] = {reqWin.tgtAddr[`BFLY_ADDR_W-2:0], 1'b0,
                           reqWin.iniAddr, reqWin.wdata};
    assign respData_o[o] = {1'b0, respWin.iniRoute[`BFLY_ADDR_W-1:1],
                            respWin.rdata};
  end

  // Ready goes back only along a granted path
  for (genvar k = 0; k < 2; k++) begin : genReady
    assign reqReady_o[k]  = reqGrant[reqSel[k]][k] && reqReady_i[reqSel[k]];
    assign respReady_o[k] = respGrant[respSel[k]][k] && respReady_i[respSel[k]];
  end

  for (genvar p = 0; p < 2; p++) begin : genAssert
    // Two inputs never share one output
    assert property (@(posedge clk_i) disable iff (!rstN_i)
      reqValid_o[p] |-> $onehot(reqGrant[p]))
      else $error("bflySwitchbox: request output %0d has no single grant", p);

    assert property (@(posedge clk_i) disable iff (!rstN_i)
      respValid_o[p] |-> $onehot(respGrant[p]))
      else $error("bflySwitchbox: response output %0d has no single grant", p);

    // A completed transfer was really offered by that input
    assert property (@(posedge clk_i) disable iff (!rstN_i)
      reqReady_o[p] |-> reqValid_i[p])
      else $error("bflySwitchbox: request ready on idle input %0d", p);

    assert property (@(posedge clk_i) disable iff (!rstN_i)
      respReady_o[p] |-> respValid_i[p])
      else $error("bflySwitchbox: response ready on idle input %0d", p);
  end

endmodule

// ==== bflyNet.sv ====
`timescale 1ns/1ps
`include "bfly_config.svh"

module bflyNet
  import bflyReqPkg::*;
  import bflyRespPkg::*;
(
  input  logic                                                  clk_i,
  input  logic                                                  rstN_i,
  // Initiator side
  input  logic     [`BFLY_NUM_PORTS-1:0]                        reqValid_i,
  input  bflyReqT  [`BFLY_NUM_PORTS-1:0]                        reqData_i,
  output logic     [`BFLY_NUM_PORTS-1:0]                        reqReady_o,
  output logic     [`BFLY_NUM_PORTS-1:0]                        respValid_o,
  output logic     [`BFLY_NUM_PORTS-1:0][`BFLY_RESP_DATA_W-1:0] respRdata_o,
  input  logic     [`BFLY_NUM_PORTS-1:0]                        respReady_i,
  // Target side
  output logic     [`BFLY_NUM_PORTS-1:0]                        reqValid_o,
  output bflyReqT  [`BFLY_NUM_PORTS-1:0]                        reqData_o,
  input  logic     [`BFLY_NUM_PORTS-1:0]                        reqReady_i,
  input  logic     [`BFLY_NUM_PORTS-1:0]                        respValid_i,
  input  portAddrT [`BFLY_NUM_PORTS-1:0]                        respIniAddr_i,
  input  logic     [`BFLY_NUM_PORTS-1:0][`BFLY_RESP_DATA_W-1:0] respRdata_i,
  output logic     [`BFLY_NUM_PORTS-1:0]                        respReady_o
);

  localparam int unsigned NumStages  = `BFLY_ADDR_W;
  localparam int unsigned NumRouters = `BFLY_NUM_PORTS / 2;

  // Switchbox ports, indexed [stage][router][port]
  logic     [NumStages-1:0][NumRouters-1:0][1:0] reqValidIn;
  logic     [NumStages-1:0][NumRouters-1:0][1:0] reqValidOut;
  logic     [NumStages-1:0][NumRouters-1:0][1:0] reqReadyIn;
  logic     [NumStages-1:0][NumRouters-1:0][1:0] reqReadyOut;
  bflyReqT  [NumStages-1:0][NumRouters-1:0][1:0] reqDataIn;
  bflyReqT  [NumStages-1:0][NumRouters-1:0][1:0] reqDataOut;
  logic     [NumStages-1:0][NumRouters-1:0][1:0] respValidIn;
  logic     [NumStages-1:0][NumRouters-1:0][1:0] respValidOut;
  logic     [NumStages-1:0][NumRouters-1:0][1:0] respReadyIn;
  logic     [NumStages-1:0][NumRouters-1:0][1:0] respReadyOut;
  bflyRespT [NumStages-1:0][NumRouters-1:0][1:0] respDataIn;
  bflyRespT [NumStages-1:0][NumRouters-1:0][1:0] respDataOut;

  portAddrT reqPrio;
  portAddrT respPrio;

  // Priority moves on after any completed handshake at the network edge
  bflyPrioLfsr #(
    .Seed(`BFLY_REQ_SEED)
  ) iReqLfsr (
    .clk_i    (clk_i),
    .rstN_i   (rstN_i),
    .advance_i(|(reqValid_o & reqReady_i)),
    .prio_o   (reqPrio)
  );

  bflyPrioLfsr #(
    .Seed(`BFLY_RESP_SEED)
  ) iRespLfsr (
    .clk_i    (clk_i),
    .rstN_i   (rstN_i),
    .advance_i(|(respValid_o & respReady_i)),
    .prio_o   (respPrio)
  );

  for (genvar p = 0; p < `BFLY_NUM_PORTS; p++) begin : genEdge
    // Initiators enter stage 0, the sender index is stamped here
    assign reqValidIn[0][p/2][p%2]  = reqValid_i[p];
    assign reqDataIn[0][p/2][p%2]   = {reqData_i[p].tgtAddr, portAddrT'(p), reqData_i[p].wdata};
    assign reqReady_o[p]            = reqReadyOut[0][p/2][p%2];
    assign respValid_o[p]           = respValidOut[0][p/2][p%2];
    assign respRdata_o[p]           = respDataOut[0][p/2][p%2].rdata;
    assign respReadyIn[0][p/2][p%2] = respReady_i[p];

    // Targets leave the last stage
    assign reqValid_o[p]                        = reqValidOut[NumStages-1][p/2][p%2];
    assign reqData_o[p]                         = reqDataOut[NumStages-1][p/2][p%2];
    assign reqReadyIn[NumStages-1][p/2][p%2]    = reqReady_i[p];
    assign respValidIn[NumStages-1][p/2][p%2]   = respValid_i[p];
    assign respReady_o[p]                       = respReadyOut[NumStages-1][p/2][p%2];

    // Last stage takes address bit 1 upward, stage 0 takes bit 0
    assign respDataIn[NumStages-1][p/2][p%2] = {respIniAddr_i[p][0],
                                                respIniAddr_i[p][`BFLY_ADDR_W-1:1],
                                                respRdata_i[p]};
  end

  // Perfect shuffle between neighbouring stages
  for (genvar l = 0; l < NumStages - 1; l++) begin : genShuffle
    localparam int unsigned Pow = 2 ** (NumStages - l - 2);
    for (genvar r = 0; r < NumRouters; r++) begin : genRouter
      for (genvar s = 0; s < 2; s++) begin : genPort
        localparam int unsigned K = Pow * s + (r % Pow) + (r / Pow / 2) * Pow * 2;
        localparam int unsigned J = (r / Pow) % 2;

        assign reqValidIn[l+1][K][J]  = reqValidOut[l][r][s];
        assign reqDataIn[l+1][K][J]   = reqDataOut[l][r][s];
        assign reqReadyIn[l][r][s]    = reqReadyOut[l+1][K][J];
        assign respValidIn[l][r][s]   = respValidOut[l+1][K][J];
        assign respDataIn[l][r][s]    = respDataOut[l+1][K][J];
        assign respReadyIn[l+1][K][J] = respReadyOut[l][r][s];
      end
    end
  end

  for (genvar l = 0; l < NumStages; l++) begin : genStage
    for (genvar r = 0; r < NumRouters; r++) begin : genBox
      bflySwitchbox iSwitchbox (
        .clk_i      (clk_i),
        .rstN_i     (rstN_i),
        .reqValid_i (reqValidIn[l][r]),
        .reqData_i  (reqDataIn[l][r]),
        .reqReady_o (reqReadyOut[l][r]),
        .reqValid_o (reqValidOut[l][r]),
        .reqData_o  (reqDataOut[l][r]),
        .reqReady_i (reqReadyIn[l][r]),
        .respValid_i(respValidIn[l][r]),
        .respData_i (respDataIn[l][r]),
        .respReady_o(respReadyOut[l][r]),
        .respValid_o(respValidOut[l][r]),
        .respData_o (respDataOut[l][r]),
        .respReady_i(respReadyIn[l][r]),
        .reqPrio_i  (reqPrio[l]),
        .respPrio_i (respPrio[l])
      );
    end
  end

endmodule

// ==== bflyClockGen.sv ====
`timescale 1ns/1ps

module bflyClockGen #(
  parameter int PeriodNs    = 20,
  parameter int ResetCycles = 3
) (
  output logic clk_o,
  output logic rstN_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Reset drops at time zero and lifts on a rising edge
  initial begin
    rstN_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rstN_o <= 1'b1;
  end

endmodule

// ==== bflyNetTb.sv ====
`timescale 1ns/1ps
`include "bfly_config.svh"

module bflyNetTb
  import bflyReqPkg::*;
();

  localparam int NumPorts   = `BFLY_NUM_PORTS;
  localparam int NumRandom  = 300;
  localparam int NumTrans   = 3 * NumPorts + NumRandom;
  localparam int CycleLimit = 4 * NumTrans + 200;

  // Reply waiting in a target model
  typedef struct packed {
    portAddrT                     ini;
    logic [`BFLY_RESP_DATA_W-1:0] rdata;
  } pendRespT;

  logic clk;
  logic rstN;
  logic     [NumPorts-1:0]                        reqValid_i, reqReady_o, reqValid_o, reqReady_i;
  bflyReqT  [NumPorts-1:0]                        reqData_i, reqData_o;
  logic     [NumPorts-1:0]                        respValid_i, respReady_o;
  logic     [NumPorts-1:0]                        respValid_o, respReady_i;
  portAddrT [NumPorts-1:0]                        respIniAddr_i;
  logic     [NumPorts-1:0][`BFLY_RESP_DATA_W-1:0] respRdata_i, respRdata_o;

  integer seed;
  int issued, respDone, cycles, checks, valueErrors, transferErrors, pending, rnd;
  logic [NumPorts-1:0] holdLow;
  logic singleMode;
  int singleIni, singleTgt;

  // Expectations are indexed by initiator * NumPorts + target
  bflyReqT                      iniQ    [NumPorts][$];
  pendRespT                     tgtQ    [NumPorts][$];
  logic [`BFLY_REQ_DATA_W-1:0]  expReq  [NumPorts*NumPorts][$];
  logic [`BFLY_RESP_DATA_W-1:0] expResp [NumPorts*NumPorts][$];

  bflyClockGen #(.PeriodNs(20), .ResetCycles(3)) iClockGen (.clk_o(clk), .rstN_o(rstN));

  bflyNet UUT (
    .clk_i(clk), .rstN_i(rstN),
    .reqValid_i(reqValid_i), .reqData_i(reqData_i), .reqReady_o(reqReady_o),
    .respValid_o(respValid_o), .respRdata_o(respRdata_o), .respReady_i(respReady_i),
    .reqValid_o(reqValid_o), .reqData_o(reqData_o), .reqReady_i(reqReady_i),
    .respValid_i(respValid_i), .respIniAddr_i(respIniAddr_i), .respRdata_i(respRdata_i),
    .respReady_o(respReady_o)
  );

  // Top bits of a target reply carry the target index so a response names its source
  function automatic logic [31:0] refRdata(input logic [31:0] wdata, input int tgt);
    return {portAddrT'(tgt), wdata[28:0] ^ 29'h0B5E_3A71};
  endfunction

  task automatic checkReq(input bflyReqT expected, input bflyReqT actual, input int port);
    checks++;
    if (actual !== expected) begin
      $display("Error at %0t: reqData_o[%0d] expected %h, got %h", $time, port, expected, actual);
      valueErrors++;
    end
  endtask

  task automatic checkResp(input logic [31:0] expected, input logic [31:0] actual, input int port);
    checks++;
    if (actual !== expected) begin
      $display("Error at %0t: respRdata_o[%0d] expected %h, got %h", $time, port, expected, actual);
      valueErrors++;
    end
  endtask

  task automatic transferError(input string what);
    $display("At %0t: %s", $time, what);
    transferErrors++;
  endtask

  // The iniAddr sent is scrambled so the network has to stamp the real index
  task automatic issueReq(input int ini, input int tgt);
    bflyReqT r;
    r.tgtAddr = portAddrT'(tgt);
    r.iniAddr = portAddrT'(~ini);
    r.wdata   = ($random(seed) & 32'hFFF0_0000) | issued;
    iniQ[ini].push_back(r);
    expReq[ini*NumPorts+tgt].push_back(r.wdata);
    issued++;
  endtask

  task automatic waitDrained();
    while (respDone != issued) @(negedge clk);
  endtask

  task automatic reportCounts();
    $display("Checks: %0d, value errors: %0d, transfer errors: %0d",
             checks, valueErrors, transferErrors);
  endtask

  // Initiator and target models
  always @(posedge clk) begin
    pendRespT reply;
    if (rstN) begin
      for (int j = 0; j < NumPorts; j++) begin
        if (respValid_i[j] && respReady_o[j]) void'(tgtQ[j].pop_front());
        if (reqValid_o[j] && reqReady_i[j]) begin
          reply.ini   = reqData_o[j].iniAddr;
          reply.rdata = refRdata(reqData_o[j].wdata, j);
          tgtQ[j].push_back(reply);
        end
        if (reqValid_i[j] && reqReady_o[j]) void'(iniQ[j].pop_front());
      end
      rnd = $random(seed);
      for (int j = 0; j < NumPorts; j++) begin
        reqValid_i[j]  <= iniQ[j].size() != 0;
        if (iniQ[j].size() != 0) reqData_i[j] <= iniQ[j][0];
        respValid_i[j] <= tgtQ[j].size() != 0;
        if (tgtQ[j].size() != 0) begin
          respIniAddr_i[j] <= tgtQ[j][0].ini;
          respRdata_i[j]   <= tgtQ[j][0].rdata;
        end
        reqReady_i[j]  <= !holdLow[j] && (rnd[2*j +: 2] != 2'b00);
        respReady_i[j] <= rnd[16+2*j +: 2] != 2'b00;
      end
    end
  end

  // Compare every handshake on both edges of the network
  always @(posedge clk) begin
    bflyReqT gotReq;
    bflyReqT wantReq;
    logic [NumPorts-1:0] fromTgt;
    logic [NumPorts-1:0] toIni;
    int ini;
    int tgt;
    if (rstN) begin
      fromTgt = '0;
      toIni   = '0;
      for (int j = 0; j < NumPorts; j++) begin
        if (reqValid_o[j] && reqReady_i[j]) begin
          gotReq = reqData_o[j];
          // Sender is the initiator whose accepted request names this target
          ini = -1;
          for (int i = 0; i < NumPorts; i++) begin
            if (reqValid_i[i] && reqReady_o[i] && reqData_i[i].tgtAddr == portAddrT'(j))
              ini = i;
          end
          if (ini < 0) begin
            transferError($sformatf("target %0d accepted a request that no initiator handed over",
                                    j));
          end else begin
            fromTgt[ini] = 1'b1;
            wantReq.tgtAddr = '0;
            wantReq.iniAddr = portAddrT'(ini);
            wantReq.wdata   = expReq[ini*NumPorts+j].pop_front();
            checkReq(wantReq, gotReq, j);
            expResp[ini*NumPorts+j].push_back(refRdata(wantReq.wdata, j));
          end
        end
        if (respValid_i[j] && respReady_o[j]) toIni[respIniAddr_i[j]] = 1'b1;
      end
      if (fromTgt != (reqValid_i & reqReady_o))
        transferError("request handshakes at initiators and targets do not match");
      if (toIni != (respValid_o & respReady_i))
        transferError("response handshakes at targets and initiators do not match");
      for (int i = 0; i < NumPorts; i++) begin
        if (respValid_o[i] && respReady_i[i]) begin
          respDone++;
          tgt = int'(respRdata_o[i][31:29]);
          if (expResp[i*NumPorts+tgt].size() == 0)
            transferError($sformatf("initiator %0d got a response it never asked for", i));
          else
            checkResp(expResp[i*NumPorts+tgt].pop_front(), respRdata_o[i], i);
        end
      end
      if (singleMode && ((reqValid_o & ~(NumPorts'(1) << singleTgt)) != '0))
        transferError($sformatf("a request for target %0d showed up elsewhere", singleTgt));
      if (singleMode && ((respValid_o & ~(NumPorts'(1) << singleIni)) != '0))
        transferError($sformatf("a response for initiator %0d showed up elsewhere", singleIni));
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("Timeout after %0d cycles with %0d of %0d transactions unfinished",
               cycles, issued - respDone, issued);
      reportCounts();
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    seed = 71159;
    {issued, respDone, cycles, checks, valueErrors, transferErrors} = '0;
    {reqValid_i, reqData_i, reqReady_i, respReady_i} = '0;
    {respValid_i, respIniAddr_i, respRdata_i} = '0;
    holdLow    = '0;
    singleMode = 1'b0;
    @(posedge rstN);
    @(negedge clk);
    if (reqValid_o != '0 || respValid_o != '0)
      transferError("valid outputs are high after reset with idle inputs");

    // One request at a time to a different target each
    singleMode = 1'b1;
    for (int i = 0; i < NumPorts; i++) begin
      singleIni = i;
      singleTgt = (i * 3 + 5) % NumPorts;
      issueReq(i, singleTgt);
      waitDrained();
    end
    singleMode = 1'b0;

    // Every initiator aims at one target
    for (int i = 0; i < NumPorts; i++) issueReq(i, 5);
    waitDrained();

    // Target 2 stalls and its requests have to wait
    holdLow[2] = 1'b1;
    for (int i = 0; i < NumPorts; i++) issueReq(i, 2);
    repeat (10) @(negedge clk);
    pending = 0;
    foreach (iniQ[i]) pending += iniQ[i].size();
    if (!reqValid_o[2])
      transferError("requests waiting for target 2 are not offered to it");
    if (pending != NumPorts)
      transferError("requests for target 2 were accepted while its ready was held low");
    holdLow[2] = 1'b0;
    waitDrained();

    for (int k = 0; k < NumRandom; k++) begin
      rnd = $random(seed);
      issueReq(rnd[2:0], rnd[5:3]);
    end
    waitDrained();

    repeat (4) @(negedge clk);
    for (int k = 0; k < NumPorts * NumPorts; k++) begin
      if (expReq[k].size() != 0 || expResp[k].size() != 0)
        transferError($sformatf("transfers from initiator %0d to target %0d never completed",
                                k / NumPorts, k % NumPorts));
    end
    reportCounts();
    if (valueErrors == 0 && transferErrors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+.
bflyReqPkg.sv
bflyRespPkg.sv
bflyPrioLfsr.sv
bflySwitchbox.sv
bflyNet.sv
bflyClockGen.sv
bflyNetTb.sv
